// ==== tile_pkg.sv ====
// shared widths, request struct and address map, imported by every tile module
`default_nettype none

package tile_pkg;

	typedef logic [31:0] word_t;
	typedef logic [31:0] addr_t;
	typedef logic [3:0]  byte_en_t;
	typedef logic [1:0]  sfr_idx_t;

	// one request without its strobe, 69 bits
	typedef struct packed {
		logic     we;
		addr_t    addr;
		byte_en_t be;
		word_t    wdata;
	} mem_cmd_t;

	// core requests with this bit set go to the external bus
	localparam int unsigned XBUS_SEL_BIT = 31;

	// local requests with this bit set go to the sfr block, else ram
	localparam int unsigned SFR_SEL_BIT = 30;

	// sfr register index sits in addr[3:2]
	localparam int unsigned SFR_IDX_LSB = 2;

	localparam sfr_idx_t SFR_ID_IDX      = 2'd0;
	localparam sfr_idx_t SFR_SCRATCH_IDX = 2'd1;

endpackage

`default_nettype wire

// ==== tile_ram.sv ====
// single-port word RAM with byte-enabled writes and one-cycle read response
`default_nettype none
`timescale 1ns/10ps

module tile_ram
#(
	parameter int unsigned MEM_WORDS = 1024
)
(
	input  wire logic                 clk_i
	, input  wire logic               arst_n_i
	, input  wire logic               req_i
	, input  wire tile_pkg::mem_cmd_t cmd_i
	, output logic                    resp_o
	, output tile_pkg::word_t         rdata_o
);

	import tile_pkg::*;

	localparam int unsigned IDX_W = $clog2(MEM_WORDS);
	localparam int unsigned LANES = $bits(byte_en_t);

	word_t            mem [MEM_WORDS];
	logic [IDX_W-1:0] idx;

	// word index, upper address bits alias
	assign idx = cmd_i.addr[IDX_W+1:2];

	always_ff @(posedge clk_i)
	begin
		if (req_i)
		begin
			if (cmd_i.we)
			begin
				for (int b = 0; b < LANES; b++)
					if (cmd_i.be[b])
						mem[idx][8*b +: 8] <= cmd_i.wdata[8*b +: 8];
			end
			else
				rdata_o <= mem[idx];
		end
	end

	always_ff @(posedge clk_i or negedge arst_n_i)
	begin
		if (!arst_n_i)
			resp_o <= 1'b0;
		else
			resp_o <= req_i & ~cmd_i.we;
	end

endmodule

`default_nettype wire

// ==== tile_sfr.sv ====
// special-function registers, read-only core number and a byte-writable scratch word
`default_nettype none
`timescale 1ns/10ps

module tile_sfr
#(
	parameter tile_pkg::word_t CORENUM = '0
)
(
	input  wire logic                 clk_i
	, input  wire logic               arst_n_i
	, input  wire logic               req_i
	, input  wire tile_pkg::mem_cmd_t cmd_i
	, output logic                    resp_o
	, output tile_pkg::word_t         rdata_o
);

	import tile_pkg::*;

	sfr_idx_t idx;
	word_t    scratch_q;
	word_t    rd_word;

	assign idx = cmd_i.addr[SFR_IDX_LSB +: $bits(sfr_idx_t)];

	always_comb
	begin
		case (idx)
			SFR_ID_IDX:      rd_word = CORENUM;
			SFR_SCRATCH_IDX: rd_word = scratch_q;
			default:         rd_word = '0;
		endcase
	end

	always_ff @(posedge clk_i or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			scratch_q <= '0;
			resp_o    <= 1'b0;
		end
		else
		begin
			resp_o <= req_i & ~cmd_i.we;
			if (req_i && cmd_i.we && idx == SFR_SCRATCH_IDX)
			begin
				for (int b = 0; b < $bits(byte_en_t); b++)
					if (cmd_i.be[b])
						scratch_q[8*b +: 8] <= cmd_i.wdata[8*b +: 8];
			end
		end
	end

	// read word held for the response cycle
	always_ff @(posedge clk_i)
	begin
		if (req_i && !cmd_i.we)
			rdata_o <= rd_word;
	end

endmodule

`default_nettype wire

// ==== tile_local_decode.sv ====
// third stage, steers local requests to ram or sfr and merges their read data
`default_nettype none
`timescale 1ns/10ps

module tile_local_decode
#(
	parameter int unsigned       MEM_WORDS = 1024
	, parameter tile_pkg::word_t CORENUM   = '0
)
(
	input  wire logic              clk_i
	, input  wire logic            arst_n_i

	, input  wire logic            int_req_i
	, input  wire tile_pkg::mem_cmd_t int_cmd_i
	, output logic                 int_ack_o
	, output logic                 int_resp_o
	, output tile_pkg::word_t      int_rdata_o
);

	import tile_pkg::*;

	logic  ram_req;
	logic  sfr_req;
	logic  ram_resp;
	logic  sfr_resp;
	word_t ram_rdata;
	word_t sfr_rdata;

	// both targets take one request per cycle
	assign int_ack_o = int_req_i;

	assign sfr_req = int_req_i & int_cmd_i.addr[SFR_SEL_BIT];
	assign ram_req = int_req_i & ~int_cmd_i.addr[SFR_SEL_BIT];

	// at most one target answers per cycle
	assign int_resp_o  = ram_resp | sfr_resp;
	assign int_rdata_o = sfr_resp ? sfr_rdata : ram_rdata;

	tile_ram #(
		.MEM_WORDS (MEM_WORDS)
	) u_ram (
		.clk_i      (clk_i)
		, .arst_n_i (arst_n_i)
		, .req_i    (ram_req)
		, .cmd_i    (int_cmd_i)
		, .resp_o   (ram_resp)
		, .rdata_o  (ram_rdata)
	);

	tile_sfr #(
		.CORENUM (CORENUM)
	) u_sfr (
		.clk_i      (clk_i)
		, .arst_n_i (arst_n_i)
		, .req_i    (sfr_req)
		, .cmd_i    (int_cmd_i)
		, .resp_o   (sfr_resp)
		, .rdata_o  (sfr_rdata)
	);

endmodule

`default_nettype wire

// ==== tile_host_arb.sv ====
// second stage, round-robin arbiter between the core-local port and the host port
`default_nettype none
`timescale 1ns/10ps

module tile_host_arb
(
	input  wire logic              clk_i
	, input  wire logic            arst_n_i

	, input  wire logic            loc_req_i
	, input  wire tile_pkg::mem_cmd_t loc_cmd_i
	, output logic                 loc_ack_o
	, output logic                 loc_resp_o
	, output tile_pkg::word_t      loc_rdata_o

	, input  wire logic            hpi_req_i
	, input  wire tile_pkg::mem_cmd_t hpi_cmd_i
	, output logic                 hpi_ack_o
	, output logic                 hpi_resp_o
	, output tile_pkg::word_t      hpi_rdata_o

	, output logic                 int_req_o
	, output tile_pkg::mem_cmd_t   int_cmd_o
	, input  wire logic            int_ack_i
	, input  wire logic            int_resp_i
	, input  wire tile_pkg::word_t int_rdata_i
);

	import tile_pkg::*;

	logic gnt_host;
	logic gnt_core;
	logic accept;
	logic last_host_q;
	logic own_host_q;

	// host wins when alone or when the core had the last grant
	assign gnt_host = hpi_req_i & (~loc_req_i | ~last_host_q);
	assign gnt_core = loc_req_i & ~gnt_host;

	assign int_req_o = loc_req_i | hpi_req_i;
	assign int_cmd_o = gnt_host ? hpi_cmd_i : loc_cmd_i;
	assign accept    = int_req_o & int_ack_i;

	assign loc_ack_o = gnt_core & int_ack_i;
	assign hpi_ack_o = gnt_host & int_ack_i;

	// read data comes back exactly one cycle after accept
	assign loc_resp_o  = int_resp_i & ~own_host_q;
	assign hpi_resp_o  = int_resp_i & own_host_q;
	assign loc_rdata_o = int_rdata_i;
	assign hpi_rdata_o = int_rdata_i;

	always_ff @(posedge clk_i or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			// start as if the host went last
			last_host_q <= 1'b1;
			own_host_q  <= 1'b0;
		end
		else
		begin
			if (accept)
				last_host_q <= gnt_host;
			if (accept && !int_cmd_o.we)
				own_host_q <= gnt_host;
		end
	end

endmodule

`default_nettype wire

// ==== tile_xbus_split.sv ====
// first stage, splits core requests between the external bus and the local fabric
`default_nettype none
`timescale 1ns/10ps

module tile_xbus_split
(
	input  wire logic              clk_i
	, input  wire logic            arst_n_i

	, input  wire logic            core_req_i
	, input  wire tile_pkg::mem_cmd_t core_cmd_i
	, output logic                 core_ack_o
	, output logic                 core_resp_o
	, output tile_pkg::word_t      core_rdata_o

	, output logic                 loc_req_o
	, output tile_pkg::mem_cmd_t   loc_cmd_o
	, input  wire logic            loc_ack_i
	, input  wire logic            loc_resp_i
	, input  wire tile_pkg::word_t loc_rdata_i

	, output logic                 xbus_req_o
	, output tile_pkg::mem_cmd_t   xbus_cmd_o
	, input  wire logic            xbus_ack_i
	, input  wire logic            xbus_resp_i
	, input  wire tile_pkg::word_t xbus_rdata_i
);

	import tile_pkg::*;

	localparam int unsigned CNT_W = 4;

	logic             to_xbus;
	logic             xrd_issue;
	logic [CNT_W-1:0] xrd_cnt_q;

	assign to_xbus = core_cmd_i.addr[XBUS_SEL_BIT];

	assign xbus_req_o = core_req_i & to_xbus;
	assign xbus_cmd_o = core_cmd_i;

	// local side waits until every external read has come back
	assign loc_req_o = core_req_i & ~to_xbus & (xrd_cnt_q == '0);
	assign loc_cmd_o = core_cmd_i;

	assign core_ack_o = (xbus_req_o & xbus_ack_i) | loc_ack_i;

	assign core_resp_o  = loc_resp_i | xbus_resp_i;
	assign core_rdata_o = xbus_resp_i ? xbus_rdata_i : loc_rdata_i;

	assign xrd_issue = xbus_req_o & xbus_ack_i & ~core_cmd_i.we;

	// outstanding external reads
	always_ff @(posedge clk_i or negedge arst_n_i)
	begin
		if (!arst_n_i)
			xrd_cnt_q <= '0;
		else
			xrd_cnt_q <= xrd_cnt_q + CNT_W'(xrd_issue) - CNT_W'(xbus_resp_i);
	end

endmodule

`default_nettype wire

// ==== magma_tile.sv ====
// tile memory fabric top, chains xbus split, host arbiter and local decode
`default_nettype none
`timescale 1ns/10ps

module magma_tile
#(
	parameter int unsigned       MEM_WORDS = 1024
	, parameter tile_pkg::word_t CORENUM   = '0
)
(
	input  wire logic                 clk_i
	, input  wire logic               arst_n_i

	, input  wire logic               core_req_i
	, input  wire tile_pkg::mem_cmd_t core_cmd_i
	, output logic                    core_ack_o
	, output logic                    core_resp_o
	, output tile_pkg::word_t         core_rdata_o

	, input  wire logic               hpi_req_i
	, input  wire tile_pkg::mem_cmd_t hpi_cmd_i
	, output logic                    hpi_ack_o
	, output logic                    hpi_resp_o
	, output tile_pkg::word_t         hpi_rdata_o

	, output logic                    xbus_req_o
	, output tile_pkg::mem_cmd_t      xbus_cmd_o
	, input  wire logic               xbus_ack_i
	, input  wire logic               xbus_resp_i
	, input  wire tile_pkg::word_t    xbus_rdata_i
);

	import tile_pkg::*;

	logic     loc_req;
	mem_cmd_t loc_cmd;
	logic     loc_ack;
	logic     loc_resp;
	word_t    loc_rdata;

	logic     int_req;
	mem_cmd_t int_cmd;
	logic     int_ack;
	logic     int_resp;
	word_t    int_rdata;

	tile_xbus_split u_xbus_split (
		.clk_i          (clk_i)
		, .arst_n_i     (arst_n_i)
		, .core_req_i   (core_req_i)
		, .core_cmd_i   (core_cmd_i)
		, .core_ack_o   (core_ack_o)
		, .core_resp_o  (core_resp_o)
		, .core_rdata_o (core_rdata_o)
		, .loc_req_o    (loc_req)
		, .loc_cmd_o    (loc_cmd)
		, .loc_ack_i    (loc_ack)
		, .loc_resp_i   (loc_resp)
		, .loc_rdata_i  (loc_rdata)
		, .xbus_req_o   (xbus_req_o)
		, .xbus_cmd_o   (xbus_cmd_o)
		, .xbus_ack_i   (xbus_ack_i)
		, .xbus_resp_i  (xbus_resp_i)
		, .xbus_rdata_i (xbus_rdata_i)
	);

	tile_host_arb u_host_arb (
		.clk_i         (clk_i)
		, .arst_n_i    (arst_n_i)
		, .loc_req_i   (loc_req)
		, .loc_cmd_i   (loc_cmd)
		, .loc_ack_o   (loc_ack)
		, .loc_resp_o  (loc_resp)
		, .loc_rdata_o (loc_rdata)
		, .hpi_req_i   (hpi_req_i)
		, .hpi_cmd_i   (hpi_cmd_i)
		, .hpi_ack_o   (hpi_ack_o)
		, .hpi_resp_o  (hpi_resp_o)
		, .hpi_rdata_o (hpi_rdata_o)
		, .int_req_o   (int_req)
		, .int_cmd_o   (int_cmd)
		, .int_ack_i   (int_ack)
		, .int_resp_i  (int_resp)
		, .int_rdata_i (int_rdata)
	);

	tile_local_decode #(
		.MEM_WORDS (MEM_WORDS)
		, .CORENUM (CORENUM)
	) u_local_decode (
		.clk_i         (clk_i)
		, .arst_n_i    (arst_n_i)
		, .int_req_i   (int_req)
		, .int_cmd_i   (int_cmd)
		, .int_ack_o   (int_ack)
		, .int_resp_o  (int_resp)
		, .int_rdata_o (int_rdata)
	);

endmodule

`default_nettype wire

// ==== magma_tile_chk.sv ====
// port-level protocol assertions for the tile that bind into every magma_tile instance
`default_nettype none
`timescale 1ns/10ps

module magma_tile_chk
(
	input  wire logic                 clk_i
	, input  wire logic               arst_n_i
	, input  wire logic               core_req_i
	, input  wire tile_pkg::mem_cmd_t core_cmd_i
	, input  wire logic               core_ack_i
	, input  wire logic               core_resp_i
	, input  wire logic               hpi_req_i
	, input  wire tile_pkg::mem_cmd_t hpi_cmd_i
	, input  wire logic               hpi_ack_i
	, input  wire logic               hpi_resp_i
	, input  wire logic               xbus_req_i
	, input  wire tile_pkg::mem_cmd_t xbus_cmd_i
	, input  wire logic               xbus_ack_i
	, input  wire logic               xbus_resp_i
);

	import tile_pkg::*;

	int unsigned fail_cnt = 0;
	logic [3:0]  xrd_open_q;
	logic        core_loc;
	logic        core_loc_ack;

	// core wants the local fabric and nothing external is pending
	assign core_loc     = core_req_i & ~core_cmd_i.addr[XBUS_SEL_BIT] & (xrd_open_q == '0);
	assign core_loc_ack = core_ack_i & ~xbus_req_i;

	always_ff @(posedge clk_i or negedge arst_n_i)
	begin
		if (!arst_n_i)
			xrd_open_q <= '0;
		else
			xrd_open_q <= xrd_open_q + 4'(xbus_req_i & xbus_ack_i & ~xbus_cmd_i.we)
				- 4'(xbus_resp_i);
	end

	task automatic flag_failure(input string what);
		fail_cnt++;
		$error("%s", what);
	endtask

	reset_quiet: assert property (@(posedge clk_i)
		!arst_n_i |-> !(core_ack_i | core_resp_i | hpi_ack_i | hpi_resp_i | xbus_req_i))
		else flag_failure("control output active during reset");

	hpi_resp_has_ack: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		hpi_resp_i |-> $past(hpi_ack_i & ~hpi_cmd_i.we))
		else flag_failure("hpi response without a read ack one cycle before");

	core_resp_has_ack: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		core_resp_i |-> $past(core_loc_ack & ~core_cmd_i.we) || (xrd_open_q != '0))
		else flag_failure("core response without a local read ack or an open xbus read");

	hpi_read_latency: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		hpi_ack_i && !hpi_cmd_i.we |=> hpi_resp_i)
		else flag_failure("hpi read response not one cycle after ack");

	core_read_latency: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		core_loc_ack && !core_cmd_i.we |=> core_resp_i)
		else flag_failure("core local read response not one cycle after ack");

	xbus_follows_core: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		core_req_i && core_cmd_i.addr[XBUS_SEL_BIT] |->
			xbus_req_i && xbus_cmd_i == core_cmd_i)
		else flag_failure("core external access not forwarded to xbus");

	local_held: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		(xrd_open_q != '0) && core_req_i && !core_cmd_i.addr[XBUS_SEL_BIT] |-> !core_ack_i)
		else flag_failure("core local request acked while an xbus read is open");

	host_no_double: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		hpi_ack_i && core_loc |=> !(hpi_ack_i && core_loc))
		else flag_failure("host granted twice in a row while core waited");

	core_no_double: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		core_loc_ack && hpi_req_i |=> !(core_loc_ack && hpi_req_i))
		else flag_failure("core granted twice in a row while host waited");

endmodule

bind magma_tile magma_tile_chk u_chk (
	.clk_i         (clk_i)
	, .arst_n_i    (arst_n_i)
	, .core_req_i  (core_req_i)
	, .core_cmd_i  (core_cmd_i)
	, .core_ack_i  (core_ack_o)
	, .core_resp_i (core_resp_o)
	, .hpi_req_i   (hpi_req_i)
	, .hpi_cmd_i   (hpi_cmd_i)
	, .hpi_ack_i   (hpi_ack_o)
	, .hpi_resp_i  (hpi_resp_o)
	, .xbus_req_i  (xbus_req_o)
	, .xbus_cmd_i  (xbus_cmd_o)
	, .xbus_ack_i  (xbus_ack_i)
	, .xbus_resp_i (xbus_resp_i)
);

`default_nettype wire

// ==== tb_magma_tile.sv ====
// testbench for the tile memory fabric that drives the core and host ports and models the external bus
`default_nettype none
`timescale 1ns/10ps

module tb_magma_tile;

	import tile_pkg::*;

	localparam int unsigned MEM_WORDS = 64;
	localparam word_t       CORENUM   = 32'd5;
	localparam int unsigned IDX_W     = $clog2(MEM_WORDS);
	localparam int unsigned N_INIT    = MEM_WORDS;
	localparam int unsigned N_RND     = 24;
	localparam int unsigned N_SFR     = 12;
	localparam int unsigned N_XBUS    = 12;
	// fill, random writes and reads on both masters, sfr pairs, xbus mix with host reads
	localparam int unsigned N_TXN     = N_INIT + 4 * N_RND + N_SFR + 3 * N_XBUS;
	localparam int unsigned TIMEOUT   = 40 * N_TXN + 200;
	localparam addr_t       SFR_BASE   = addr_t'(1) << SFR_SEL_BIT;
	localparam addr_t       XBUS_BASE  = addr_t'(1) << XBUS_SEL_BIT;
	localparam addr_t       LOCAL_MASK = 32'h3fff_fffc;

	logic     clk_i;
	logic     arst_n_i;
	logic     core_req_i;
	mem_cmd_t core_cmd_i;
	logic     core_ack_o;
	logic     core_resp_o;
	word_t    core_rdata_o;
	logic     hpi_req_i;
	mem_cmd_t hpi_cmd_i;
	logic     hpi_ack_o;
	logic     hpi_resp_o;
	word_t    hpi_rdata_o;
	logic     xbus_req_o;
	mem_cmd_t xbus_cmd_o;
	logic     xbus_ack_i;
	logic     xbus_resp_i;
	word_t    xbus_rdata_i;

	word_t       shadow [MEM_WORDS];
	word_t       scratch_sh;
	word_t       core_q [$];
	word_t       hpi_q [$];
	int unsigned err_cnt   = 0;
	int unsigned cyc       = 0;
	int unsigned lcg_state = 48882;

	magma_tile #(
		.MEM_WORDS (MEM_WORDS)
		, .CORENUM (CORENUM)
	) uut (.*);

	function automatic int unsigned rand_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		// fold the better high bits down
		return lcg_state ^ (lcg_state >> 16);
	endfunction

	function automatic word_t xbus_data(input addr_t addr);
		return {addr[15:0], addr[31:16]} ^ 32'h6c3a_95e1;
	endfunction

	function automatic word_t merge_bytes(input word_t old, input word_t wdata, input byte_en_t be);
		word_t res;
		res = old;
		for (int b = 0; b < $bits(byte_en_t); b++)
			if (be[b])
				res[8*b +: 8] = wdata[8*b +: 8];
		return res;
	endfunction

	function automatic mem_cmd_t rand_cmd(input bit we, input addr_t base, input addr_t mask);
		mem_cmd_t c;
		c.we    = we;
		c.addr  = base | (addr_t'(rand_next()) & mask);
		c.be    = byte_en_t'(rand_next());
		c.wdata = rand_next();
		return c;
	endfunction

	// reference model in accept order that gives the value a read must return
	function automatic word_t model_access(input mem_cmd_t cmd);
		word_t rd;
		rd = '0;
		if (cmd.addr[XBUS_SEL_BIT])
			rd = xbus_data(cmd.addr);
		else if (cmd.addr[SFR_SEL_BIT])
		begin
			if (cmd.addr[3:2] == SFR_ID_IDX)
				rd = CORENUM;
			else if (cmd.addr[3:2] == SFR_SCRATCH_IDX)
			begin
				if (cmd.we)
					scratch_sh = merge_bytes(scratch_sh, cmd.wdata, cmd.be);
				rd = scratch_sh;
			end
		end
		else
		begin
			if (cmd.we)
				shadow[cmd.addr[IDX_W+1:2]] = merge_bytes(shadow[cmd.addr[IDX_W+1:2]],
					cmd.wdata, cmd.be);
			rd = shadow[cmd.addr[IDX_W+1:2]];
		end
		return rd;
	endfunction

	// one request on a master port held until acked
	task automatic issue(input bit host, input mem_cmd_t cmd);
		word_t rd;
		@(negedge clk_i);
		if (host)
		begin
			hpi_req_i = 1'b1;
			hpi_cmd_i = cmd;
		end
		else
		begin
			core_req_i = 1'b1;
			core_cmd_i = cmd;
		end
		do
			@(posedge clk_i);
		while (!(host ? hpi_ack_o : core_ack_o));
		rd = model_access(cmd);
		if (!cmd.we && host)
			hpi_q.push_back(rd);
		else if (!cmd.we)
			core_q.push_back(rd);
	endtask

	task automatic release_req(input bit host);
		@(negedge clk_i);
		if (host)
			hpi_req_i = 1'b0;
		else
			core_req_i = 1'b0;
	endtask

	// host fills odd words and core even words with full enables
	task automatic fill_ram(input bit host);
		mem_cmd_t c;
		for (int i = int'(host); i < MEM_WORDS; i += 2)
		begin
			c    = rand_cmd(1'b1, addr_t'(i) << 2, '0);
			c.be = '1;
			issue(host, c);
		end
		release_req(host);
	endtask

	task automatic random_local(input bit host);
		addr_t    addrs [N_RND];
		mem_cmd_t c;
		for (int i = 0; i < N_RND; i++)
		begin
			c        = rand_cmd(1'b1, '0, LOCAL_MASK);
			addrs[i] = c.addr;
			issue(host, c);
		end
		for (int i = 0; i < N_RND; i++)
			issue(host, rand_cmd(1'b0, addrs[i], '0));
		release_req(host);
	endtask

	// write then read each sfr index so scratch gets hit twice
	task automatic sfr_checks();
		mem_cmd_t c;
		for (int i = 0; i < N_SFR / 2; i++)
		begin
			c = rand_cmd(1'b1, SFR_BASE | (addr_t'(i % 4) << 2), '0);
			issue(1'b1, c);
			c.we = 1'b0;
			issue(1'b1, c);
		end
		release_req(1'b1);
	endtask

	// each external access is followed by a local read that may be held
	task automatic xbus_mix();
		for (int i = 0; i < N_XBUS; i++)
		begin
			issue(1'b0, rand_cmd(rand_next() % 2 == 0, XBUS_BASE, 32'h7fff_fffc));
			issue(1'b0, rand_cmd(1'b0, '0, LOCAL_MASK));
		end
		release_req(1'b0);
	endtask

	task automatic local_reads(input bit host);
		for (int i = 0; i < N_XBUS; i++)
			issue(host, rand_cmd(1'b0, '0, LOCAL_MASK));
		release_req(host);
	endtask

	task automatic check_resp(input string name, ref word_t q[$], input word_t got);
		word_t exp;
		if (q.size() == 0)
		begin
			$display("%s: a response arrived with no read pending", name);
			err_cnt++;
		end
		else
		begin
			exp = q.pop_front();
			assert (got === exp)
			else
			begin
				$display("[FAIL] %s expected %h got %h", name, exp, got);
				err_cnt++;
			end
		end
	endtask

	initial
	begin
		clk_i = 1'b0;
		forever
			#20 clk_i = ~clk_i;
	end

	always @(posedge clk_i)
		cyc <= cyc + 1;

	always @(posedge clk_i)
	begin
		if (hpi_resp_o)
			check_resp("hpi_rdata_o", hpi_q, hpi_rdata_o);
		if (core_resp_o)
			check_resp("core_rdata_o", core_q, core_rdata_o);
	end

	// external bus model acks after 0 to 3 cycles and answers reads 1 to 4 cycles after the ack
	initial
	begin : xbus_model
		addr_t       rd_addr [$];
		int unsigned rd_due [$];
		int unsigned t;
		int unsigned wait_cnt;
		int unsigned ack_delay;
		t         = 0;
		wait_cnt  = 0;
		ack_delay = rand_next() % 4;
		forever
		begin
			@(posedge clk_i);
			t++;
			if (xbus_req_o && xbus_ack_i)
			begin
				if (!xbus_cmd_o.we)
				begin
					rd_addr.push_back(xbus_cmd_o.addr);
					rd_due.push_back(t + rand_next() % 4);
				end
				wait_cnt  = 0;
				ack_delay = rand_next() % 4;
			end
			else if (xbus_req_o)
				wait_cnt++;
			@(negedge clk_i);
			xbus_ack_i  = (wait_cnt >= ack_delay);
			xbus_resp_i = 1'b0;
			if (rd_due.size() != 0 && t >= rd_due[0])
			begin
				xbus_resp_i  = 1'b1;
				xbus_rdata_i = xbus_data(rd_addr.pop_front());
				void'(rd_due.pop_front());
			end
		end
	end

	initial
	begin : watchdog
		do
			@(posedge clk_i);
		while (cyc < TIMEOUT);
		$display("timeout, the run did not finish within %0d cycles", TIMEOUT);
		$display("errors: %0d testbench, %0d assertion", err_cnt, uut.u_chk.fail_cnt);
		$display("Regression failed");
		$finish;
	end

	initial
	begin : main
		int unsigned drain;
		arst_n_i     = 1'b0;
		core_req_i   = 1'b0;
		core_cmd_i   = '0;
		hpi_req_i    = 1'b0;
		hpi_cmd_i    = '0;
		xbus_ack_i   = 1'b0;
		xbus_resp_i  = 1'b0;
		xbus_rdata_i = '0;
		scratch_sh   = '0;
		repeat (3) @(negedge clk_i);
		arst_n_i = 1'b1;

		fork
			fill_ram(1'b1);
			fill_ram(1'b0);
		join
		fork
			random_local(1'b1);
			random_local(1'b0);
		join
		sfr_checks();
		fork
			xbus_mix();
			local_reads(1'b1);
		join

		drain = 0;
		while ((core_q.size() != 0 || hpi_q.size() != 0) && drain < 20)
		begin
			@(negedge clk_i);
			drain++;
		end
		if (core_q.size() != 0 || hpi_q.size() != 0)
		begin
			$display("missing read responses: %0d core, %0d host", core_q.size(), hpi_q.size());
			err_cnt++;
		end

		$display("errors: %0d testbench, %0d assertion", err_cnt, uut.u_chk.fail_cnt);
		if (err_cnt == 0 && uut.u_chk.fail_cnt == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
tile_pkg.sv
tile_ram.sv
tile_sfr.sv
tile_local_decode.sv
tile_host_arb.sv
tile_xbus_split.sv
magma_tile.sv
magma_tile_chk.sv
tb_magma_tile.sv

// ==== Bender.yml ====
package:
  name: magma_tile

sources:
  - tile_pkg.sv
  - tile_ram.sv
  - tile_sfr.sv
  - tile_local_decode.sv
  - tile_host_arb.sv
  - tile_xbus_split.sv
  - magma_tile.sv
  - target: simulation
    files:
      - magma_tile_chk.sv
      - tb_magma_tile.sv
